/* files.f */
logic/pkt_pkg.sv
logic/pkt_classifier.sv
logic/pkt_fifo.sv
logic/prio_scheduler.sv
logic/pkt_queue_top.sv
tb/pkt_queue_properties.sv
tb/pkt_queue_tb.sv

/* logic/pkt_classifier.sv */
`timescale 1ns/1ps

module pkt_classifier import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_vld,
    input  beat_t               wr_beat,
    output logic [NUM_PRIO-1:0] q_wr,
    output beat_t               q_beat
);

    // packet in progress on the write stream
    logic              pkt_open;
    // queue of the open packet
    logic [PRIO_W-1:0] cur_prio;

    logic              accept;
    logic [PRIO_W-1:0] tgt_prio;
    logic [NUM_PRIO-1:0] tgt_onehot;

    // start beat only when closed, continuation only when open
    // stray beats and repeated starts fall through
    assign accept = wr_vld && (wr_beat.sop ? !pkt_open : pkt_open);

    // start beat carries the priority in its top bits
    assign tgt_prio = wr_beat.sop ? wr_beat.data[DATA_W-1 -: PRIO_W] : cur_prio;

    always_comb begin
        tgt_onehot = '0;
        tgt_onehot[tgt_prio] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_open <= 1'b0;
            cur_prio <= '0;
            q_wr     <= '0;
        end else begin
            q_wr <= accept ? tgt_onehot : '0;
            if (accept) begin
                // single-beat packet leaves the stream closed
                pkt_open <= !wr_beat.eop;
                if (wr_beat.sop) begin
                    cur_prio <= tgt_prio;
                end
            end
        end
    end

    // beat follows q_wr by the same one cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            q_beat <= wr_beat;
        end
    end

endmodule

/* logic/pkt_fifo.sv */
`timescale 1ns/1ps

module pkt_fifo import pkt_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr,
    input  beat_t wr_beat,
    input  logic  pop,
    output beat_t head,
    output logic  pkt_ready,
    output logic  drop
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    // extra msb tells full from empty
    localparam logic [ADDR_W:0] FULL_CNT = (ADDR_W + 1)'(FIFO_DEPTH);
    // step for pointers and the packet count
    localparam logic [ADDR_W:0] PTR_ONE  = (ADDR_W + 1)'(1);

    beat_t mem [FIFO_DEPTH];

    // read side
    logic [ADDR_W:0] rd_ptr;
    // tentative write pointer of the open packet
    logic [ADDR_W:0] wr_tmp;
    // committed write pointer at the end of the last complete packet
    logic [ADDR_W:0] wr_cmt;
    // count of complete packets up to FIFO_DEPTH
    logic [ADDR_W:0] pkt_cnt;
    // rest of the current packet is being thrown away
    logic            dropping;

    logic [ADDR_W:0] used;
    logic            full;
    logic            store;
    logic            commit;
    logic            release_pkt;

    // occupancy counts uncommitted beats too
    assign used = wr_tmp - rd_ptr;
    assign full = (used == FULL_CNT);

    // beat lands in memory
    assign store  = wr && !dropping && !full;
    // last beat of a packet that fit
    assign commit = store && wr_beat.eop;
    // end beat leaves with the pop
    assign release_pkt = pop && head.eop;

    assign head = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            wr_tmp    <= '0;
            wr_cmt    <= '0;
            pkt_cnt   <= '0;
            dropping  <= 1'b0;
            drop      <= 1'b0;
            pkt_ready <= 1'b0;
        end else begin
            drop <= 1'b0;

            if (wr) begin
                if (dropping) begin
                    // swallow beats up to the end beat
                    if (wr_beat.eop) begin
                        dropping <= 1'b0;
                        drop     <= 1'b1;
                    end
                end else if (full) begin
                    // no room so rewind to the last committed packet
                    wr_tmp <= wr_cmt;
                    if (wr_beat.eop) begin
                        drop <= 1'b1;
                    end else begin
                        dropping <= 1'b1;
                    end
                end else begin
                    wr_tmp <= wr_tmp + PTR_ONE;
                    if (wr_beat.eop) begin
                        wr_cmt <= wr_tmp + PTR_ONE;
                    end
                end
            end

            if (pop) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end

            // both ends may move at one edge
            case ({commit, release_pkt})
                2'b10:   pkt_cnt <= pkt_cnt + PTR_ONE;
                2'b01:   pkt_cnt <= pkt_cnt - PTR_ONE;
                default: pkt_cnt <= pkt_cnt;
            endcase

            // follows the count one cycle later
            pkt_ready <= (pkt_cnt != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            mem[wr_tmp[ADDR_W-1:0]] <= wr_beat;
        end
    end

endmodule

/* logic/pkt_pkg.sv */
package pkt_pkg;

    // beat payload width
    localparam int DATA_W = 16;

    // priority queues, queue 0 wins
    localparam int NUM_PRIO = 4;

    // priority index width, taken from the top data bits of the start beat
    localparam int PRIO_W = 2;

    // one beat on any internal or external beat path
    typedef struct packed {
        logic              sop;
        logic              eop;
        logic [DATA_W-1:0] data;
    } beat_t;

    // scheduler FSM
    // idle waits for a committed packet
    // sel locks one queue
    // req holds out_req until ack
    // ack_low waits for ack release, then pops
    typedef enum logic [1:0] {
        IDLE,
        SEL,
        REQ,
        ACK_LOW
    } sched_state_t;

endpackage

/* logic/pkt_queue_top.sv */
`timescale 1ns/1ps

module pkt_queue_top import pkt_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_vld,
    input  beat_t       wr_beat,
    output logic        out_req,
    output beat_t       out_beat,
    input  logic        out_ack,
    output logic [15:0] drop_count
);

    logic [NUM_PRIO-1:0] q_wr;
    beat_t               q_beat;
    logic [NUM_PRIO-1:0] pkt_ready;
    logic [NUM_PRIO-1:0] pop;
    logic [NUM_PRIO-1:0] drop;
    beat_t               heads [NUM_PRIO];

    // several queues may drop in the same cycle
    logic [PRIO_W:0]     drop_sum;

    pkt_classifier u_classifier (
        .clk     (clk),
        .rst     (rst),
        .wr_vld  (wr_vld),
        .wr_beat (wr_beat),
        .q_wr    (q_wr),
        .q_beat  (q_beat)
    );

    // one packet FIFO per priority, all fed from the same beat bus
    for (genvar g = 0; g < NUM_PRIO; g++) begin : g_queue
        pkt_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .wr        (q_wr[g]),
            .wr_beat   (q_beat),
            .pop       (pop[g]),
            .head      (heads[g]),
            .pkt_ready (pkt_ready[g]),
            .drop      (drop[g])
        );
    end

    prio_scheduler u_scheduler (
        .clk       (clk),
        .rst       (rst),
        .pkt_ready (pkt_ready),
        .heads     (heads),
        .pop       (pop),
        .out_req   (out_req),
        .out_beat  (out_beat),
        .out_ack   (out_ack)
    );

    always_comb begin
        drop_sum = '0;
        for (int i = 0; i < NUM_PRIO; i++) begin
            drop_sum = drop_sum + (PRIO_W + 1)'(drop[i]);
        end
    end

    // whole packets lost for lack of room
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else begin
            drop_count <= drop_count + 16'(drop_sum);
        end
    end

endmodule

/* logic/prio_scheduler.sv */
`timescale 1ns/1ps

module prio_scheduler import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [NUM_PRIO-1:0] pkt_ready,
    input  beat_t               heads [NUM_PRIO],
    output logic [NUM_PRIO-1:0] pop,
    output logic                out_req,
    output beat_t               out_beat,
    input  logic                out_ack
);

    sched_state_t      state;
    // locked queue
    logic [PRIO_W-1:0] sel;

    logic              any_ready;
    logic [PRIO_W-1:0] low_idx;
    logic              load_beat;
    beat_t             next_beat;

    // lowest-indexed ready queue
    always_comb begin
        any_ready = 1'b0;
        low_idx   = '0;
        for (int i = NUM_PRIO - 1; i >= 0; i--) begin
            if (pkt_ready[i]) begin
                any_ready = 1'b1;
                low_idx   = PRIO_W'(i);
            end
        end
    end

    // pop once the consumer has released ack
    always_comb begin
        pop = '0;
        if (state == ACK_LOW && !out_ack) begin
            pop[sel] = 1'b1;
        end
    end

    // first beat comes at sel, later beats when req is re-raised
    assign load_beat = (state == SEL && any_ready) ||
                       (state == REQ && !out_req && !out_ack);
    assign next_beat = (state == SEL) ? heads[low_idx] : heads[sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            sel     <= '0;
            out_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (any_ready) begin
                        state <= SEL;
                    end
                end
                SEL: begin
                    // ready may have been stale after the last pop
                    if (any_ready) begin
                        sel     <= low_idx;
                        out_req <= 1'b1;
                        state   <= REQ;
                    end else begin
                        state <= IDLE;
                    end
                end
                REQ: begin
                    if (out_req) begin
                        if (out_ack) begin
                            out_req <= 1'b0;
                            state   <= ACK_LOW;
                        end
                    end else if (!out_ack) begin
                        // head has advanced after the pop
                        out_req <= 1'b1;
                    end
                end
                ACK_LOW: begin
                    // queue stays locked until the end beat is done
                    if (!out_ack) begin
                        state <= out_beat.eop ? IDLE : REQ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // held steady for the whole handshake
    always_ff @(posedge clk) begin
        if (load_beat) begin
            out_beat <= next_beat;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the packet queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module pkt_queue_tb \
    -Mdir "$BUILD_DIR" -o pkt_queue_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/pkt_queue_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* tb/pkt_queue_properties.sv */
`timescale 1ns/1ps

module pkt_queue_properties import pkt_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                out_req,
    input logic                out_ack,
    input beat_t               out_beat,
    input logic [NUM_PRIO-1:0] pop
);

    // quiet output side during and right after reset
    reset_quiet: assert property (@(posedge clk) rst |=> (!out_req && pop == '0))
        else $error("out_req or pop active during or right after reset");

    // req waits for the consumer
    req_hold: assert property (@(posedge clk) disable iff (rst)
        (out_req && !out_ack) |=> out_req)
        else $error("out_req dropped before out_ack");

    // beat frozen for the whole request
    beat_stable: assert property (@(posedge clk) disable iff (rst)
        out_req |=> (!out_req || $stable(out_beat)))
        else $error("out_beat changed while out_req was high");

    // new request only after ack is released
    req_after_ack: assert property (@(posedge clk) disable iff (rst)
        (!out_req && out_ack) |=> !out_req)
        else $error("out_req rose while out_ack was still high");

endmodule

bind pkt_queue_top pkt_queue_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_beat (out_beat),
    .pop      (pop)
);

/* tb/pkt_queue_tb.sv */
`timescale 1ns/1ps

module pkt_queue_tb import pkt_pkg::*; ();

    localparam int FIFO_DEPTH = 16;
    // idle cycles after each packet so the first commit is locked alone
    localparam int PKT_GAP    = 4;
    localparam int WAIT_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        wr_vld;
    beat_t       wr_beat;
    logic        out_req;
    beat_t       out_beat;
    logic        out_ack;
    logic [15:0] drop_count;

    logic [31:0] lfsr = 32'h2996;
    int mismatches    = 0;
    int timeouts      = 0;
    int setup_errors  = 0;

    // reference model with one occupancy per queue and no pops during a batch
    int    occ [NUM_PRIO] = '{default: 0};
    int    model_drops = 0;
    int    first_kept  = -1;
    int    pkt_prio_q [$];
    int    pkt_start_q [$];
    int    pkt_len_q [$];
    beat_t batch_beats [$];
    beat_t exp_q [$];

    // req rises seen on the output since the start of the run
    int    out_beats    = 0;
    int    beats_before = 0;
    logic  req_seen     = 1'b0;

    pkt_queue_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .wr_vld     (wr_vld),
        .wr_beat    (wr_beat),
        .out_req    (out_req),
        .out_beat   (out_beat),
        .out_ack    (out_ack),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one count per four-phase cycle started by the DUT
    always @(posedge clk) begin
        if (!rst && out_req && !req_seen) begin
            out_beats++;
        end
        req_seen = out_req;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail %s: got %h, expected %h", name, got, expected);
            mismatches++;
        end
    endtask

    task automatic send_beat(input beat_t b);
        @(posedge clk);
        wr_vld  <= 1'b1;
        wr_beat <= b;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_vld <= 1'b0;
        end
    endtask

    // dup puts a second start beat right after the first one
    task automatic send_packet(input int prio, input int len, input logic [15:0] first,
                               input logic dup);
        beat_t       pkt [$];
        beat_t       b;
        logic [15:0] w;
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                w = {PRIO_W'(prio), first[DATA_W-PRIO_W-1:0]};
            end else begin
                draw_bits(16, w);
            end
            b.sop  = (i == 0);
            b.eop  = (i == len - 1);
            b.data = w;
            pkt.push_back(b);
        end
        // fits only if every beat finds room
        if (occ[prio] + len <= FIFO_DEPTH) begin
            if (first_kept < 0) begin
                first_kept = pkt_prio_q.size();
            end
            pkt_prio_q.push_back(prio);
            pkt_start_q.push_back(batch_beats.size());
            pkt_len_q.push_back(len);
            foreach (pkt[i]) batch_beats.push_back(pkt[i]);
            occ[prio] += len;
        end else begin
            model_drops++;
        end
        foreach (pkt[i]) begin
            send_beat(pkt[i]);
            if (dup && i == 0 && len > 1) begin
                draw_bits(16, w);
                b.sop  = 1'b1;
                b.eop  = 1'b0;
                b.data = w;
                send_beat(b);
            end
        end
        idle_cycles(PKT_GAP);
    endtask

    task automatic send_stray();
        beat_t       b;
        logic [15:0] w;
        logic [15:0] e;
        draw_bits(16, w);
        draw_bits(1, e);
        b.sop  = 1'b0;
        b.eop  = e[0];
        b.data = w;
        send_beat(b);
        idle_cycles(PKT_GAP);
    endtask

    task automatic queue_packet(input int k);
        for (int j = 0; j < pkt_len_q[k]; j++) begin
            exp_q.push_back(batch_beats[pkt_start_q[k] + j]);
        end
    endtask

    // locked packet first then strict priority and fifo order within a queue
    task automatic build_expected();
        exp_q.delete();
        if (first_kept >= 0) begin
            queue_packet(first_kept);
        end
        for (int p = 0; p < NUM_PRIO; p++) begin
            for (int k = 0; k < pkt_prio_q.size(); k++) begin
                if (pkt_prio_q[k] == p && k != first_kept) begin
                    queue_packet(k);
                end
            end
        end
    endtask

    task automatic wait_req(input logic level, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(posedge clk);
            if (out_req == level) begin
                ok = 1'b1;
            end
            n++;
        end
        if (!ok) begin
            $display("timeout: out_req never went to %0d after %0d cycles", level, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // four-phase consumer with random delays on both ack edges
    task automatic drain_batch(output logic ok);
        beat_t       exp_b;
        logic [15:0] d;
        ok = 1'b1;
        while (ok && exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            wait_req(1'b1, ok);
            if (ok) begin
                check_value("out_beat.sop", 32'(out_beat.sop), 32'(exp_b.sop));
                check_value("out_beat.eop", 32'(out_beat.eop), 32'(exp_b.eop));
                check_value("out_beat.data", 32'(out_beat.data), 32'(exp_b.data));
                draw_bits(3, d);
                repeat (d) @(posedge clk);
                out_ack <= 1'b1;
                wait_req(1'b0, ok);
            end
            if (ok) begin
                draw_bits(3, d);
                repeat (d) @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    endtask

    // nothing may follow the last expected beat
    task automatic check_quiet();
        for (int i = 0; i < 24; i++) begin
            @(posedge clk);
            if (out_req) begin
                check_value("out_req", 32'(out_req), 32'd0);
                break;
            end
        end
    endtask

    task automatic finish_batch(input int total, output logic ok);
        idle_cycles(PKT_GAP);
        build_expected();
        drain_batch(ok);
        if (ok) begin
            check_quiet();
            check_value("output beat count", 32'(out_beats - beats_before),
                        32'(batch_beats.size()));
            check_value("drop_count", 32'(drop_count), 32'(total));
            check_value("model drop total", 32'(model_drops), 32'(total));
        end
        beats_before = out_beats;
        pkt_prio_q.delete();
        pkt_start_q.delete();
        pkt_len_q.delete();
        batch_beats.delete();
        occ        = '{default: 0};
        first_kept = -1;
    endtask

    task automatic run_vectors();
        int          fd;
        int          rc;
        int          prio;
        int          len;
        int          total;
        string       line;
        byte         kind;
        logic [15:0] first;
        logic        ok;
        fd = $fopen("tb/pkt_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/pkt_vectors.txt");
            setup_errors++;
            return;
        end
        while (1'b1) begin
            rc = $fgets(line, fd);
            if (rc == 0) begin
                break;
            end
            if (line.len() < 1) begin
                continue;
            end
            kind = line[0];
            case (kind)
                "P", "D": begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%d %d %h", prio, len, first);
                    send_packet(prio, len, first, kind == "D");
                end
                "S": send_stray();
                "B": begin
                    rc = $sscanf(line.substr(1, line.len() - 1), "%d", total);
                    finish_batch(total, ok);
                    if (!ok) begin
                        $fclose(fd);
                        return;
                    end
                end
                // comments and blank lines
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        rst     <= 1'b1;
        wr_vld  <= 1'b0;
        wr_beat <= '0;
        out_ack <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // quiet output and zero drops before any packet
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            check_value("out_req", 32'(out_req), 32'd0);
            check_value("drop_count", 32'(drop_count), 32'd0);
        end
        run_vectors();
        $display("errors: %0d mismatches, %0d timeouts, %0d setup", mismatches, timeouts,
                 setup_errors);
        if (mismatches == 0 && timeouts == 0 && setup_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb/pkt_vectors.txt */
# P prio length first_word(hex) : packet, D : same with a repeated start beat
# S : stray beat outside a packet, B total : end of batch, cumulative drop count
# batch 1, one queue, lengths 1 to 5
P 2 1 0a01
P 2 2 0b02
P 2 3 0c03
P 2 4 0d04
P 2 5 0e05
B 0
# batch 2, mixed priorities
P 3 3 1111
P 1 2 2222
P 0 4 3333
P 2 1 4444
P 0 2 5555
P 1 3 6666
B 0
# batch 3, queue 1 overflows, queue 2 gets a packet longer than the FIFO
P 1 6 0101
P 1 6 0202
P 1 6 0303
P 1 4 0404
P 2 18 0505
P 2 3 0606
P 0 1 0707
B 2
# batch 4, stray beats and repeated start beats
S
P 3 2 7777
S
D 3 4 0888
S
S
D 0 3 0999
P 0 1 0aaa
B 2
# batch 5, start beat meets a full queue
P 0 8 1234
P 0 8 2345
P 0 1 3456
P 3 16 4567
P 3 2 5678
P 1 5 6789
B 4
# batch 6, all queues busy
P 2 4 0c0c
P 0 2 0d0d
P 3 1 0e0e
P 1 5 0f0f
P 2 2 1010
P 0 3 1212
P 1 17 1313
P 3 6 1414
B 5
